/* rtl/soc_macros.svh */
// ----------------------------------------------------------
// soc system bus parameters
// bus widths, request buffer depth, memory sizes, region
// codes of address bits 31:28 and the boot ROM content tag
// ----------------------------------------------------------
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// request buffer entries per master, equal to the initial credits
`define SOC_BUF_DEPTH 2

// memory sizes in words
`define SOC_ROM_WORDS 256
`define SOC_RAM_WORDS 256

// ----------------------------------------------------------
// region codes on address bits 31:28
// ----------------------------------------------------------
`define SOC_REGION_ROM   4'h0
`define SOC_REGION_CLINT 4'h2
`define SOC_REGION_RAM   4'h8

// upper half of every boot ROM word
`define SOC_ROM_TAG 16'hb007

`endif

/* rtl/soc_pkg.sv */
// ----------------------------------------------------------
// soc bus types
// request, response and beat structs, the two-view address
// union and the CLINT register select
// ----------------------------------------------------------
`include "soc_macros.svh"

package soc_pkg;

  // master id, 0 is core and 1 is debug
  typedef logic src_id_t;

  typedef enum logic [1:0] {
    mtime_lo    = 2'd0,
    mtime_hi    = 2'd1,
    mtimecmp_lo = 2'd2,
    mtimecmp_hi = 2'd3
  } clint_reg_e;

  // ----------------------------------------------------------
  // address views
  // ----------------------------------------------------------
  // memory view, used by ROM and RAM
  typedef struct packed {
    logic [3:0]               region;
    logic [`SOC_ADDR_W-15:0]  pad;
    logic [7:0]               idx;
    logic [1:0]               offset;
  } mem_addr_t;

  // CLINT view, padding overlaps the memory word index
  typedef struct packed {
    logic [3:0]              region;
    logic [`SOC_ADDR_W-9:0]  pad;
    clint_reg_e              sel;
    logic [1:0]              offset;
  } clint_addr_t;

  typedef union packed {
    mem_addr_t   mem;
    clint_addr_t clint;
  } bus_addr_u;

  // ----------------------------------------------------------
  // bus channels
  // ----------------------------------------------------------
  typedef struct packed {
    bus_addr_u                 addr;
    logic                      we;
    logic [`SOC_DATA_W-1:0]    wdata;
    logic [`SOC_DATA_W/8-1:0]  be;
  } bus_req_t;

  typedef struct packed {
    logic [`SOC_DATA_W-1:0] data;
    logic                   err;
    src_id_t                src;
  } bus_rsp_t;

  // what the slaves see, request tagged with its master
  typedef struct packed {
    bus_req_t req;
    src_id_t  src;
  } bus_beat_t;

endpackage

/* rtl/req_buffer.sv */
// ----------------------------------------------------------
// request buffer for one master port
// circular FIFO that returns one credit per popped entry
// ----------------------------------------------------------
module req_buffer #(
  parameter int DEPTH = 2
) (
  input  logic              clk,
  input  logic              ndmreset_n,
  input  logic              push_i,
  input  soc_pkg::bus_req_t push_req_i,
  output logic              head_valid_o,
  output soc_pkg::bus_req_t head_o,
  input  logic              pop_i,
  output logic              credit_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  soc_pkg::bus_req_t mem_q [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [PTR_W:0]    count_q;
  logic              do_push;
  logic              do_pop;

  assign head_valid_o = (count_q != '0);
  assign head_o       = mem_q[rd_ptr_q];

  // a master with credits never pushes into a full buffer
  assign do_push = push_i && (count_q != (PTR_W+1)'(DEPTH));
  assign do_pop  = pop_i && head_valid_o;

  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_o <= 1'b0;
    end else begin
      // credit goes back the cycle after the entry leaves
      credit_o <= do_pop;
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // entry storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_req_i;
    end
  end

endmodule

/* rtl/system_bus.sv */
// ----------------------------------------------------------
// system bus
// round-robin arbiter over two buffer heads, region decode,
// registered beat to the slaves and response steering
// ----------------------------------------------------------
`include "soc_macros.svh"

module system_bus (
  input  logic                    clk,
  input  logic                    ndmreset_n,
  input  logic [1:0]              head_valid_i,
  input  soc_pkg::bus_req_t [1:0] head_i,
  output logic [1:0]              pop_o,
  output soc_pkg::bus_beat_t      beat_o,
  output logic                    rom_sel_o,
  output logic                    clint_sel_o,
  output logic                    ram_sel_o,
  input  soc_pkg::bus_rsp_t       rom_rsp_i,
  input  soc_pkg::bus_rsp_t       clint_rsp_i,
  input  soc_pkg::bus_rsp_t       ram_rsp_i,
  input  logic                    rom_rsp_valid_i,
  input  logic                    clint_rsp_valid_i,
  input  logic                    ram_rsp_valid_i,
  output logic [1:0]              rsp_valid_o,
  output soc_pkg::bus_rsp_t [1:0] rsp_o
);

  soc_pkg::src_id_t  last_q;
  soc_pkg::src_id_t  win;
  soc_pkg::src_id_t  err_src_q;
  soc_pkg::bus_req_t win_req;
  soc_pkg::bus_rsp_t err_rsp;
  soc_pkg::bus_rsp_t rsp;
  logic              any_req;
  logic [3:0]        region;
  logic              hit_rom;
  logic              hit_clint;
  logic              hit_ram;
  logic              err_sel_q;
  logic              err_valid_q;
  logic              any_rsp;

  // ----------------------------------------------------------
  // arbitration
  // ----------------------------------------------------------
  // on a tie the master not granted last time wins
  always_comb begin
    if (head_valid_i == 2'b11) begin
      win = ~last_q;
    end else if (head_valid_i[1]) begin
      win = 1'b1;
    end else begin
      win = 1'b0;
    end
  end

  assign any_req = |head_valid_i;
  assign pop_o   = any_req ? (2'b01 << win) : 2'b00;
  assign win_req = head_i[win];

  // region decode, ROM writes fall through to the error path
  assign region    = win_req.addr.mem.region;
  assign hit_rom   = (region == `SOC_REGION_ROM) && !win_req.we;
  assign hit_clint = (region == `SOC_REGION_CLINT);
  assign hit_ram   = (region == `SOC_REGION_RAM);

  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      last_q      <= 1'b1;
      rom_sel_o   <= 1'b0;
      clint_sel_o <= 1'b0;
      ram_sel_o   <= 1'b0;
      err_sel_q   <= 1'b0;
      err_valid_q <= 1'b0;
    end else begin
      rom_sel_o   <= any_req && hit_rom;
      clint_sel_o <= any_req && hit_clint;
      ram_sel_o   <= any_req && hit_ram;
      err_sel_q   <= any_req && !(hit_rom || hit_clint || hit_ram);
      // error answer lines up with the slaves' one-cycle delay
      err_valid_q <= err_sel_q;
      if (any_req) begin
        last_q <= win;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (any_req) begin
      beat_o.req <= win_req;
      beat_o.src <= win;
    end
    err_src_q <= beat_o.src;
  end

  // ----------------------------------------------------------
  // response steering
  // ----------------------------------------------------------
  assign err_rsp.data = '0;
  assign err_rsp.err  = 1'b1;
  assign err_rsp.src  = err_src_q;

  // only one select per cycle, so at most one of these is valid
  always_comb begin
    if (rom_rsp_valid_i) begin
      rsp = rom_rsp_i;
    end else if (clint_rsp_valid_i) begin
      rsp = clint_rsp_i;
    end else if (ram_rsp_valid_i) begin
      rsp = ram_rsp_i;
    end else begin
      rsp = err_rsp;
    end
  end

  assign any_rsp     = rom_rsp_valid_i || clint_rsp_valid_i || ram_rsp_valid_i || err_valid_q;
  assign rsp_valid_o = any_rsp ? (2'b01 << rsp.src) : 2'b00;
  assign rsp_o       = {rsp, rsp};

endmodule

/* rtl/boot_rom.sv */
// ----------------------------------------------------------
// boot ROM
// word i holds the content tag over the index i
// ----------------------------------------------------------
`include "soc_macros.svh"

module boot_rom (
  input  logic               clk,
  input  logic               sel_i,
  input  soc_pkg::bus_beat_t beat_i,
  output logic               rsp_valid_o,
  output soc_pkg::bus_rsp_t  rsp_o
);

  logic [`SOC_DATA_W-1:0] rom [`SOC_ROM_WORDS];

  // content table
  for (genvar i = 0; i < `SOC_ROM_WORDS; i++) begin : g_rom
    assign rom[i] = {`SOC_ROM_TAG, 16'(i)};
  end

  always_ff @(posedge clk) begin
    rsp_valid_o <= sel_i;
    if (sel_i) begin
      rsp_o.data <= rom[beat_i.req.addr.mem.idx];
      rsp_o.err  <= 1'b0;
      rsp_o.src  <= beat_i.src;
    end
  end

endmodule

/* rtl/scratch_ram.sv */
// ----------------------------------------------------------
// scratch RAM
// word array with byte-enabled writes, one-cycle response
// ----------------------------------------------------------
`include "soc_macros.svh"

module scratch_ram (
  input  logic               clk,
  input  logic               sel_i,
  input  soc_pkg::bus_beat_t beat_i,
  output logic               rsp_valid_o,
  output soc_pkg::bus_rsp_t  rsp_o
);

  logic [`SOC_DATA_W-1:0] mem_q [`SOC_RAM_WORDS];
  logic [7:0]             idx;

  assign idx = beat_i.req.addr.mem.idx;

  always_ff @(posedge clk) begin
    rsp_valid_o <= sel_i;
    if (sel_i) begin
      rsp_o.err <= 1'b0;
      rsp_o.src <= beat_i.src;
      if (beat_i.req.we) begin
        // only enabled lanes change
        for (int b = 0; b < `SOC_DATA_W/8; b++) begin
          if (beat_i.req.be[b]) begin
            mem_q[idx][8*b +: 8] <= beat_i.req.wdata[8*b +: 8];
          end
        end
        rsp_o.data <= '0;
      end else begin
        rsp_o.data <= mem_q[idx];
      end
    end
  end

endmodule

/* rtl/clint_timer.sv */
// ----------------------------------------------------------
// CLINT timer
// half-rate real-time tick, 64-bit mtime and mtimecmp,
// timer interrupt while mtime has reached mtimecmp
// ----------------------------------------------------------
`include "soc_macros.svh"

module clint_timer (
  input  logic               clk,
  input  logic               ndmreset_n,
  input  logic               sel_i,
  input  soc_pkg::bus_beat_t beat_i,
  output logic               rsp_valid_o,
  output soc_pkg::bus_rsp_t  rsp_o,
  output logic               timer_irq_o
);

  logic                rtc_q;
  logic [63:0]         mtime_q;
  logic [63:0]         mtimecmp_q;
  soc_pkg::clint_reg_e reg_sel;
  logic                wr;

  assign reg_sel = beat_i.req.addr.clint.sel;
  assign wr      = sel_i && beat_i.req.we;

  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_q       <= 1'b0;
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      rsp_valid_o <= 1'b0;
    end else begin
      // tick toggles every cycle, mtime counts while it is high
      rtc_q       <= ~rtc_q;
      rsp_valid_o <= sel_i;
      if (rtc_q) begin
        mtime_q <= mtime_q + 64'd1;
      end
      // mtime writes are dropped
      for (int b = 0; b < `SOC_DATA_W/8; b++) begin
        if (wr && beat_i.req.be[b]) begin
          if (reg_sel == soc_pkg::mtimecmp_lo) begin
            mtimecmp_q[8*b +: 8] <= beat_i.req.wdata[8*b +: 8];
          end else if (reg_sel == soc_pkg::mtimecmp_hi) begin
            mtimecmp_q[32 + 8*b +: 8] <= beat_i.req.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // ----------------------------------------------------------
  // read response
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (sel_i) begin
      rsp_o.err <= 1'b0;
      rsp_o.src <= beat_i.src;
      if (beat_i.req.we) begin
        rsp_o.data <= '0;
      end else begin
        case (reg_sel)
          soc_pkg::mtime_lo:    rsp_o.data <= mtime_q[31:0];
          soc_pkg::mtime_hi:    rsp_o.data <= mtime_q[63:32];
          soc_pkg::mtimecmp_lo: rsp_o.data <= mtimecmp_q[31:0];
          default:              rsp_o.data <= mtimecmp_q[63:32];
        endcase
      end
    end
  end

  assign timer_irq_o = (mtime_q >= mtimecmp_q);

endmodule

/* rtl/soc_top.sv */
// ----------------------------------------------------------
// soc system bus top level
// two credit-managed master ports into one bus with boot
// ROM, CLINT timer and scratch RAM
// ----------------------------------------------------------
`include "soc_macros.svh"

module soc_top (
  input  logic                    clk,
  input  logic                    ndmreset_n,
  input  logic [1:0]              req_valid_i,
  input  soc_pkg::bus_req_t [1:0] req_i,
  output logic [1:0]              credit_o,
  output logic [1:0]              rsp_valid_o,
  output soc_pkg::bus_rsp_t [1:0] rsp_o,
  output logic                    timer_irq_o
);

  logic [1:0]              head_valid;
  soc_pkg::bus_req_t [1:0] head;
  logic [1:0]              pop;
  soc_pkg::bus_beat_t      beat;
  logic                    rom_sel;
  logic                    clint_sel;
  logic                    ram_sel;
  soc_pkg::bus_rsp_t       rom_rsp;
  soc_pkg::bus_rsp_t       clint_rsp;
  soc_pkg::bus_rsp_t       ram_rsp;
  logic                    rom_rsp_valid;
  logic                    clint_rsp_valid;
  logic                    ram_rsp_valid;

  // ----------------------------------------------------------
  // master ports, 0 core and 1 debug
  // ----------------------------------------------------------
  for (genvar m = 0; m < 2; m++) begin : g_buf
    req_buffer #(
      .DEPTH ( `SOC_BUF_DEPTH )
    ) i_req_buffer (
      .clk          ( clk            ),
      .ndmreset_n   ( ndmreset_n     ),
      .push_i       ( req_valid_i[m] ),
      .push_req_i   ( req_i[m]       ),
      .head_valid_o ( head_valid[m]  ),
      .head_o       ( head[m]        ),
      .pop_i        ( pop[m]         ),
      .credit_o     ( credit_o[m]    )
    );
  end

  system_bus i_system_bus (
    .clk               ( clk             ),
    .ndmreset_n        ( ndmreset_n      ),
    .head_valid_i      ( head_valid      ),
    .head_i            ( head            ),
    .pop_o             ( pop             ),
    .beat_o            ( beat            ),
    .rom_sel_o         ( rom_sel         ),
    .clint_sel_o       ( clint_sel       ),
    .ram_sel_o         ( ram_sel         ),
    .rom_rsp_i         ( rom_rsp         ),
    .clint_rsp_i       ( clint_rsp       ),
    .ram_rsp_i         ( ram_rsp         ),
    .rom_rsp_valid_i   ( rom_rsp_valid   ),
    .clint_rsp_valid_i ( clint_rsp_valid ),
    .ram_rsp_valid_i   ( ram_rsp_valid   ),
    .rsp_valid_o       ( rsp_valid_o     ),
    .rsp_o             ( rsp_o           )
  );

  // ----------------------------------------------------------
  // slaves
  // ----------------------------------------------------------
  boot_rom i_boot_rom (
    .clk         ( clk           ),
    .sel_i       ( rom_sel       ),
    .beat_i      ( beat          ),
    .rsp_valid_o ( rom_rsp_valid ),
    .rsp_o       ( rom_rsp       )
  );

  clint_timer i_clint_timer (
    .clk         ( clk             ),
    .ndmreset_n  ( ndmreset_n      ),
    .sel_i       ( clint_sel       ),
    .beat_i      ( beat            ),
    .rsp_valid_o ( clint_rsp_valid ),
    .rsp_o       ( clint_rsp       ),
    .timer_irq_o ( timer_irq_o     )
  );

  scratch_ram i_scratch_ram (
    .clk         ( clk           ),
    .sel_i       ( ram_sel       ),
    .beat_i      ( beat          ),
    .rsp_valid_o ( ram_rsp_valid ),
    .rsp_o       ( ram_rsp       )
  );

endmodule

/* verification/soc_properties.sv */
// ----------------------------------------------------------
// system bus properties
// slave select, response and pop rules on every cycle
// ----------------------------------------------------------
module soc_properties (
  input logic       clk,
  input logic       ndmreset_n,
  input logic [1:0] head_valid_i,
  input logic [1:0] pop_i,
  input logic       rom_sel_i,
  input logic       clint_sel_i,
  input logic       ram_sel_i,
  input logic       err_sel_i,
  input logic [1:0] rsp_valid_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int         fail_count = 0;
  logic [3:0] sel;

  assign sel = {rom_sel_i, clint_sel_i, ram_sel_i, err_sel_i};

  // one slave, or the error path, per beat
  a_one_sel: assert property (@(posedge clk) disable iff (!ndmreset_n) $onehot0(sel))
    else begin
      fail_count++;
      $error("more than one slave select in one cycle");
    end

  // every response answers the beat of the cycle before
  a_rsp_after_beat: assert property (@(posedge clk) disable iff (!ndmreset_n)
    (rsp_valid_i != 2'b00) |-> $past(|sel))
    else begin
      fail_count++;
      $error("response without a beat one cycle earlier");
    end

  a_pop_valid: assert property (@(posedge clk) disable iff (!ndmreset_n)
    (pop_i & ~head_valid_i) == 2'b00)
    else begin
      fail_count++;
      $error("pop of an empty request buffer");
    end

endmodule

bind system_bus soc_properties i_soc_properties (
  .clk          ( clk          ),
  .ndmreset_n   ( ndmreset_n   ),
  .head_valid_i ( head_valid_i ),
  .pop_i        ( pop_o        ),
  .rom_sel_i    ( rom_sel_o    ),
  .clint_sel_i  ( clint_sel_o  ),
  .ram_sel_i    ( ram_sel_o    ),
  .err_sel_i    ( err_sel_q    ),
  .rsp_valid_i  ( rsp_valid_o  )
);

/* verification/tb_soc_top.sv */
// ----------------------------------------------------------
// soc system bus testbench
// directed tests through credit-tracking master drivers,
// response capture, checker, watchdog and summary
// ----------------------------------------------------------
`include "soc_macros.svh"

module tb_soc_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 10;
  localparam int DEPTH        = `SOC_BUF_DEPTH;
  localparam int WAIT_CYCLES  = 50;
  // timer 6, rom 4, ram 3, errors 3, bursts 4 per buffer slot
  localparam int NUM_TXNS     = 16 + 4 * DEPTH;
  localparam int WATCHDOG     = 2 * (RESET_CYCLES + NUM_TXNS * WAIT_CYCLES);

  logic                    clk;
  logic                    ndmreset_n;
  logic [1:0]              req_valid;
  soc_pkg::bus_req_t [1:0] req;
  logic [1:0]              credit;
  logic [1:0]              rsp_valid;
  soc_pkg::bus_rsp_t [1:0] rsp;
  logic                    timer_irq;

  int                spent [2];
  int                returned [2];
  soc_pkg::bus_rsp_t rsp_q [2][$];
  int                errors;
  int                checks;
  int                tests;

  initial clk = 1'b0;
  always #10 clk = ~clk;

  soc_top dut (
    .clk         ( clk        ),
    .ndmreset_n  ( ndmreset_n ),
    .req_valid_i ( req_valid  ),
    .req_i       ( req        ),
    .credit_o    ( credit     ),
    .rsp_valid_o ( rsp_valid  ),
    .rsp_o       ( rsp        ),
    .timer_irq_o ( timer_irq  )
  );

  // credits and responses sampled mid-cycle
  always @(negedge clk) begin
    if (ndmreset_n) begin
      for (int m = 0; m < 2; m++) begin
        if (credit[m]) begin
          returned[m]++;
        end
        if (rsp_valid[m]) begin
          rsp_q[m].push_back(rsp[m]);
        end
      end
    end
  end

  // ----------------------------------------------------------
  // helpers
  // ----------------------------------------------------------
  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("Error: %s", msg);
  endtask

  task automatic finish_test(input string name, input int start_errors);
    tests++;
    if (errors == start_errors) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - start_errors);
    end
  endtask

  function automatic logic [31:0] mem_addr(input logic [3:0] region, input logic [17:0] pad,
                                           input logic [7:0] idx);
    return {region, pad, idx, 2'b00};
  endfunction

  function automatic logic [31:0] clint_addr(input logic [1:0] sel);
    return {`SOC_REGION_CLINT, 24'h0, sel, 2'b00};
  endfunction

  // tag over the word index
  function automatic logic [31:0] rom_word(input logic [7:0] idx);
    return {`SOC_ROM_TAG, 8'h00, idx};
  endfunction

  function automatic soc_pkg::bus_req_t build_req(input logic [31:0] addr, input logic we,
                                                  input logic [31:0] wdata, input logic [3:0] be);
    soc_pkg::bus_req_t r;
    r.addr  = addr;
    r.we    = we;
    r.wdata = wdata;
    r.be    = be;
    return r;
  endfunction

  // one request per cycle while a credit is held
  task automatic send_req(input int m, input soc_pkg::bus_req_t r);
    int waited;
    waited = 0;
    @(posedge clk);
    #1;
    while (spent[m] - returned[m] >= DEPTH && waited < WAIT_CYCLES) begin
      req_valid[m] = 1'b0;
      waited++;
      @(posedge clk);
      #1;
    end
    if (waited >= WAIT_CYCLES) begin
      report_error($sformatf("master %0d never got a credit back", m));
    end else begin
      req_valid[m] = 1'b1;
      req[m]       = r;
      spent[m]++;
    end
  endtask

  task automatic release_port(input int m);
    @(posedge clk);
    #1;
    req_valid[m] = 1'b0;
  endtask

  task automatic wait_rsp(input int m, output soc_pkg::bus_rsp_t r);
    int waited;
    waited = 0;
    r      = '0;
    while (rsp_q[m].size() == 0 && waited < WAIT_CYCLES) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (rsp_q[m].size() == 0) begin
      report_error($sformatf("master %0d received no response", m));
    end else begin
      r = rsp_q[m].pop_front();
      check_val($sformatf("master %0d response id", m), m, r.src);
    end
  endtask

  task automatic transact(input int m, input logic [31:0] addr, input logic we,
                          input logic [31:0] wdata, input logic [3:0] be,
                          output soc_pkg::bus_rsp_t r);
    send_req(m, build_req(addr, we, wdata, be));
    release_port(m);
    wait_rsp(m, r);
  endtask

  // ----------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------
  task automatic test_timer();
    soc_pkg::bus_rsp_t r;
    logic [31:0]       t0;
    int                e0;
    e0 = errors;
    check_val("timer irq after reset", 0, timer_irq);
    transact(0, clint_addr(2'd0), 1'b0, '0, 4'hf, r);
    t0 = r.data;
    transact(0, clint_addr(2'd0), 1'b0, '0, 4'hf, r);
    if (r.data <= t0) begin
      report_error("mtime did not advance between two reads");
    end
    // upper half first so mtimecmp never passes through a low value early
    transact(1, clint_addr(2'd3), 1'b1, 32'h0, 4'hf, r);
    transact(1, clint_addr(2'd2), 1'b1, 32'h1, 4'hf, r);
    check_val("timer write error flag", 0, r.err);
    check_val("timer irq at mtimecmp 1", 1, timer_irq);
    transact(1, clint_addr(2'd3), 1'b1, '1, 4'hf, r);
    transact(1, clint_addr(2'd2), 1'b1, '1, 4'hf, r);
    check_val("timer irq at mtimecmp all ones", 0, timer_irq);
    finish_test("timer", e0);
  endtask

  task automatic test_rom();
    soc_pkg::bus_rsp_t r;
    logic [7:0]        idx;
    logic [17:0]       pad;
    int                e0;
    e0 = errors;
    // odd k uses the debug port and an aliased padding
    for (int k = 0; k < 4; k++) begin
      idx = (k < 2) ? 8'd5 : 8'd200;
      pad = (k % 2 == 0) ? 18'h0 : 18'h2a5c3;
      transact(k % 2, mem_addr(`SOC_REGION_ROM, pad, idx), 1'b0, '0, 4'hf, r);
      check_val($sformatf("rom word %0d pass %0d", idx, k), rom_word(idx), r.data);
      check_val("rom read error flag", 0, r.err);
    end
    finish_test("rom_read", e0);
  endtask

  task automatic test_ram();
    soc_pkg::bus_rsp_t r;
    logic [31:0]       addr;
    logic [31:0]       w0;
    logic [31:0]       w1;
    int                e0;
    e0   = errors;
    w0   = $urandom();
    w1   = $urandom();
    addr = mem_addr(`SOC_REGION_RAM, 18'h0, 8'd9);
    transact(0, addr, 1'b1, w0, 4'hf, r);
    check_val("ram write data", 0, r.data);
    transact(0, addr, 1'b1, w1, 4'b0101, r);
    transact(1, addr, 1'b0, '0, 4'hf, r);
    check_val("ram merged word", {w0[31:24], w1[23:16], w0[15:8], w1[7:0]}, r.data);
    check_val("ram read error flag", 0, r.err);
    finish_test("ram_bytes", e0);
  endtask

  task automatic test_errors();
    soc_pkg::bus_rsp_t r;
    int                e0;
    e0 = errors;
    transact(0, mem_addr(`SOC_REGION_ROM, 18'h0, 8'd3), 1'b1, 32'hdeadbeef, 4'hf, r);
    check_val("rom write error flag", 1, r.err);
    check_val("rom write data", 0, r.data);
    transact(1, mem_addr(4'h4, 18'h0, 8'd7), 1'b0, '0, 4'hf, r);
    check_val("region 4 read error flag", 1, r.err);
    check_val("region 4 read data", 0, r.data);
    transact(0, mem_addr(4'h4, 18'h1, 8'd7), 1'b1, 32'h1234, 4'hf, r);
    check_val("region 4 write error flag", 1, r.err);
    finish_test("error_rsp", e0);
  endtask

  task automatic issue_burst(input int m, input logic [7:0] base);
    for (int k = 0; k < 2 * DEPTH; k++) begin
      send_req(m, build_req(mem_addr(`SOC_REGION_ROM, 18'h0, base + 8'(k)),
                            1'b0, '0, 4'hf));
      if (k == DEPTH - 1) begin
        // no credit may come back before the first entry is granted
        @(negedge clk);
        #1;
        check_val($sformatf("master %0d credits in use", m), DEPTH, spent[m] - returned[m]);
      end
    end
    release_port(m);
  endtask

  task automatic test_credits();
    soc_pkg::bus_rsp_t r;
    int                base;
    int                waited;
    int                e0;
    e0 = errors;
    fork
      issue_burst(0, 8'd16);
      issue_burst(1, 8'd48);
    join
    for (int m = 0; m < 2; m++) begin
      base = (m == 0) ? 16 : 48;
      for (int k = 0; k < 2 * DEPTH; k++) begin
        wait_rsp(m, r);
        check_val($sformatf("master %0d burst word %0d", m, k), rom_word(8'(base + k)), r.data);
      end
    end
    waited = 0;
    while ((spent[0] != returned[0] || spent[1] != returned[1]) && waited < WAIT_CYCLES) begin
      @(posedge clk);
      waited++;
    end
    check_val("core credits back", DEPTH, DEPTH - spent[0] + returned[0]);
    check_val("debug credits back", DEPTH, DEPTH - spent[1] + returned[1]);
    repeat (4) @(posedge clk);
    check_val("stray responses", 0, rsp_q[0].size() + rsp_q[1].size());
    finish_test("credits", e0);
  endtask

  // ----------------------------------------------------------
  // run
  // ----------------------------------------------------------
  initial begin
    void'($urandom(32'hf668881d));
    errors     = 0;
    checks     = 0;
    tests      = 0;
    spent      = '{0, 0};
    returned   = '{0, 0};
    ndmreset_n = 1'b0;
    req_valid  = '0;
    req        = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    ndmreset_n = 1'b1;
    test_timer();
    test_rom();
    test_ram();
    test_errors();
    test_credits();
    errors += dut.i_system_bus.i_soc_properties.fail_count;
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* sources.f */
+incdir+rtl
rtl/soc_pkg.sv
rtl/req_buffer.sv
rtl/system_bus.sv
rtl/boot_rom.sv
rtl/scratch_ram.sv
rtl/clint_timer.sv
rtl/soc_top.sv
verification/soc_properties.sv
verification/tb_soc_top.sv

/* Makefile */
# Verilator build and run of the soc system bus testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --assert --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := TEST PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --timescale $(TIMESCALE) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
